//--- Makefile
# Verilator flow for the RV32I decode stage

VERILATOR ?= verilator
FLIST     ?= build.f
TOP       ?= decoder_tb
RTL_TOP   ?= decoder_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+source
+incdir+verif
source/rv_decode_pkg.sv
source/instr_decoder.sv
source/imm_gen.sv
source/hazard_unit.sv
source/decoder_top.sv
verif/decoder_tb.sv

//--- source/decoder_top.sv
`timescale 1ns/1ns
/*
 * RV32I decode stage with valid/ready input and a one-cycle valid pulse out.
 * The output side has no back-pressure; the consumer must take each bundle.
 * Latency is one cycle from accept to dec_valid_o.
 */
module decoder_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        instr_valid_i,
    input  rv_decode_pkg::word_t        instr_i,
    input  rv_decode_pkg::word_t        instr_addr_i,
    output logic                        ready_o,
    output logic                        dec_valid_o,
    output logic                        rd_we_o,
    output logic                        use_imm_o,
    output logic                        illegal_o,
    output rv_decode_pkg::instr_class_t instr_class_o,
    output rv_decode_pkg::alu_op_t      alu_op_o,
    output rv_decode_pkg::reg_addr_t    rs1_addr_o,
    output rv_decode_pkg::reg_addr_t    rs2_addr_o,
    output rv_decode_pkg::reg_addr_t    rd_addr_o,
    output rv_decode_pkg::word_t        imm_o,
    output rv_decode_pkg::word_t        instr_addr_o,
    output rv_decode_pkg::lsu_ctrl_t    lsu_ctrl_o
);
    import rv_decode_pkg::*;

    logic         accept;
    logic         reads_rs1;
    logic         reads_rs2;
    logic         rd_writes;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    instr_class_t cls;  // Unregistered class for the immediate mux

    hazard_unit u_hazard (
        .clk_i, .rstn_i, .instr_valid_i,
        .reads_rs1_i (reads_rs1),
        .reads_rs2_i (reads_rs2),
        .rd_writes_i (rd_writes),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .rd_i        (rd),
        .ready_o,
        .accept_o    (accept)
    );

    instr_decoder u_decoder (
        .clk_i, .rstn_i,
        .accept_i    (accept),
        .instr_i, .instr_addr_i,
        .reads_rs1_o (reads_rs1),
        .reads_rs2_o (reads_rs2),
        .rd_writes_o (rd_writes),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .class_o     (cls),
        .dec_valid_o, .rd_we_o, .use_imm_o, .illegal_o, .instr_class_o,
        .alu_op_o, .rs1_addr_o, .rs2_addr_o, .rd_addr_o, .lsu_ctrl_o, .instr_addr_o
    );

    imm_gen u_imm (
        .clk_i, .rstn_i,
        .accept_i (accept),
        .instr_i,
        .class_i  (cls),
        .imm_o
    );

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/1ns
/*
 * Read-after-write stall against the instruction accepted just before.
 * A hit holds off the input for one cycle only; x0 never causes a stall.
 * Idle cycles keep the stored destination untouched.
 */
module hazard_unit (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     instr_valid_i,
    input  logic                     reads_rs1_i,
    input  logic                     reads_rs2_i,
    input  logic                     rd_writes_i,
    input  rv_decode_pkg::reg_addr_t rs1_i,
    input  rv_decode_pkg::reg_addr_t rs2_i,
    input  rv_decode_pkg::reg_addr_t rd_i,
    output logic                     ready_o,
    output logic                     accept_o
);
    import rv_decode_pkg::*;

    stall_state_t state_q;
    reg_addr_t    last_rd_q;  // Destination of the last accepted instruction
    logic         rs1_hit;
    logic         rs2_hit;
    logic         hazard;

    ////////////////////
    // Hazard detection
    ////////////////////
    assign rs1_hit = reads_rs1_i && (rs1_i != '0) && (rs1_i == last_rd_q);
    assign rs2_hit = reads_rs2_i && (rs2_i != '0) && (rs2_i == last_rd_q);

    // After one stall cycle the instruction goes through regardless
    assign hazard = instr_valid_i && (state_q == ST_RUN) && (rs1_hit || rs2_hit);

    assign ready_o  = ~hazard;
    assign accept_o = instr_valid_i & ready_o;

    ////////////////////
    // State
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rstn_i == 1'b0) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= hazard ? ST_STALL : ST_RUN;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rstn_i == 1'b0) begin
            last_rd_q <= '0;
        end else if (accept_o) begin
            // Stores and branches leave nothing to wait for
            last_rd_q <= rd_writes_i ? rd_i : '0;
        end
    end

endmodule

//--- source/imm_gen.sv
`timescale 1ns/1ns
/*
 * Immediate extraction for RV32I, format chosen by the decoded class.
 * Shift amounts are zero-extended; the formats assume a 32-bit word.
 */
module imm_gen (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        accept_i,
    input  rv_decode_pkg::word_t        instr_i,
    input  rv_decode_pkg::instr_class_t class_i,
    output rv_decode_pkg::word_t        imm_o
);
    import rv_decode_pkg::*;

    word_t imm_i_w;
    word_t imm_sh_w;
    word_t imm_s_w;
    word_t imm_b_w;
    word_t imm_u_w;
    word_t imm_j_w;
    word_t imm_next;
    logic  is_shift;

    assign imm_i_w  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_sh_w = {27'b0, instr_i[24:20]};  // shamt
    assign imm_s_w  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_w  = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_w  = {instr_i[31:12], 12'b0};
    assign imm_j_w  = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

    // SLLI/SRLI/SRAI have funct3 ending in 01
    assign is_shift = (instr_i[13:12] == 2'b01);

    always_comb begin
        case (class_i)
            // OP-IMM has opcode bit 5 clear, register-register OP has it set
            CLS_ALU:    imm_next = instr_i[5] ? '0 : (is_shift ? imm_sh_w : imm_i_w);
            CLS_LOAD,
            CLS_JALR:   imm_next = imm_i_w;
            CLS_STORE:  imm_next = imm_s_w;
            CLS_BRANCH: imm_next = imm_b_w;
            CLS_UPPER:  imm_next = imm_u_w;
            CLS_JAL:    imm_next = imm_j_w;
            default:    imm_next = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rstn_i == 1'b0) begin
            imm_o <= '0;
        end else if (accept_i) begin
            imm_o <= imm_next;
        end
    end

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/1ns
/*
 * Opcode classification and control fields for RV32I, registered on accept.
 * Register addresses that the instruction does not use come out as zero.
 * LOAD reports rd_writes for the hazard check but keeps rd_we low.
 */
module instr_decoder (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       accept_i,
    input  rv_decode_pkg::word_t       instr_i,
    input  rv_decode_pkg::word_t       instr_addr_i,
    // Combinational, towards the hazard unit and immediate generator
    output logic                       reads_rs1_o,
    output logic                       reads_rs2_o,
    output logic                       rd_writes_o,
    output rv_decode_pkg::reg_addr_t   rs1_o,
    output rv_decode_pkg::reg_addr_t   rs2_o,
    output rv_decode_pkg::reg_addr_t   rd_o,
    output rv_decode_pkg::instr_class_t class_o,
    // Registered decode bundle
    output logic                       dec_valid_o,
    output logic                       rd_we_o,
    output logic                       use_imm_o,
    output logic                       illegal_o,
    output rv_decode_pkg::instr_class_t instr_class_o,
    output rv_decode_pkg::alu_op_t     alu_op_o,
    output rv_decode_pkg::reg_addr_t   rs1_addr_o,
    output rv_decode_pkg::reg_addr_t   rs2_addr_o,
    output rv_decode_pkg::reg_addr_t   rd_addr_o,
    output rv_decode_pkg::lsu_ctrl_t   lsu_ctrl_o,
    output rv_decode_pkg::word_t       instr_addr_o
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    alu_op_t    alu_op;
    lsu_ctrl_t  lsu_ctrl;
    logic       rd_we;
    logic       use_imm;
    logic       illegal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    ////////////////////
    // Classification
    ////////////////////
    always_comb begin
        class_o     = CLS_ILLEGAL;
        alu_op      = ALU_ADD;
        lsu_ctrl    = '0;
        reads_rs1_o = 1'b0;
        reads_rs2_o = 1'b0;
        rd_writes_o = 1'b0;
        rd_we       = 1'b0;
        use_imm     = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OPC_OP: begin
                class_o     = CLS_ALU;
                alu_op      = {instr_i[30], funct3};
                reads_rs1_o = 1'b1;
                reads_rs2_o = 1'b1;
                rd_writes_o = 1'b1;
                rd_we       = 1'b1;
            end
            OPC_OPIMM: begin
                class_o     = CLS_ALU;
                // Bit 30 only selects SRAI; for other funct3 it is immediate data
                alu_op      = {(funct3[1:0] == 2'b01) & instr_i[30], funct3};
                reads_rs1_o = 1'b1;
                rd_writes_o = 1'b1;
                rd_we       = 1'b1;
                use_imm     = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                class_o     = CLS_UPPER;
                rd_writes_o = 1'b1;
                rd_we       = 1'b1;
                use_imm     = 1'b1;
            end
            OPC_LOAD: begin
                class_o     = CLS_LOAD;
                lsu_ctrl    = {1'b0, funct3};
                reads_rs1_o = 1'b1;
                rd_writes_o = 1'b1;  // Load data still lands in rd
                use_imm     = 1'b1;
            end
            OPC_STORE: begin
                class_o     = CLS_STORE;
                lsu_ctrl    = {1'b1, funct3};
                reads_rs1_o = 1'b1;
                reads_rs2_o = 1'b1;
                use_imm     = 1'b1;
            end
            OPC_BRANCH: begin
                class_o     = CLS_BRANCH;
                alu_op      = {1'b0, funct3};  // Compare type
                reads_rs1_o = 1'b1;
                reads_rs2_o = 1'b1;
                use_imm     = 1'b1;
            end
            OPC_JAL: begin
                class_o     = CLS_JAL;
                rd_writes_o = 1'b1;
                rd_we       = 1'b1;
                use_imm     = 1'b1;
            end
            OPC_JALR: begin
                class_o     = CLS_JALR;
                reads_rs1_o = 1'b1;
                rd_writes_o = 1'b1;
                rd_we       = 1'b1;
                use_imm     = 1'b1;
            end
            default: illegal = 1'b1;  // FENCE, SYSTEM and undefined
        endcase
    end

    assign rs1_o = reads_rs1_o ? instr_i[19:15] : '0;
    assign rs2_o = reads_rs2_o ? instr_i[24:20] : '0;
    assign rd_o  = rd_writes_o ? instr_i[11:7]  : '0;

    ////////////////////
    // Output register
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rstn_i == 1'b0) begin
            dec_valid_o   <= 1'b0;
            rd_we_o       <= 1'b0;
            use_imm_o     <= 1'b0;
            illegal_o     <= 1'b0;
            instr_class_o <= CLS_ALU;
            alu_op_o      <= '0;
            rs1_addr_o    <= '0;
            rs2_addr_o    <= '0;
            rd_addr_o     <= '0;
            lsu_ctrl_o    <= '0;
            instr_addr_o  <= '0;
        end else begin
            dec_valid_o <= accept_i;  // One-cycle pulse per accept
            if (accept_i) begin
                rd_we_o       <= rd_we;
                use_imm_o     <= use_imm;
                illegal_o     <= illegal;
                instr_class_o <= class_o;
                alu_op_o      <= alu_op;
                rs1_addr_o    <= rs1_o;
                rs2_addr_o    <= rs2_o;
                rd_addr_o     <= rd_o;
                lsu_ctrl_o    <= lsu_ctrl;
                instr_addr_o  <= instr_addr_i;
            end
        end
    end

endmodule

//--- source/rv_decode_pkg.sv
/*
 * Shared types and opcode constants for the RV32I decode stage.
 * FENCE and SYSTEM opcodes are intentionally absent and decode as illegal.
 */
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    ////////////////////
    // Plain vector types
    ////////////////////
    typedef logic [`XLEN-1:0]       word_t;     // Instruction, address or immediate
    typedef logic [`REG_AW-1:0]     reg_addr_t;
    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;   // {instr[30], funct3}
    typedef logic [`LSU_CTRL_W-1:0] lsu_ctrl_t; // {is_store, funct3}

    // Instruction class, replaces per-operand flags
    typedef enum logic [2:0] {
        CLS_ALU     = 3'd0,
        CLS_UPPER   = 3'd1, // LUI and AUIPC
        CLS_LOAD    = 3'd2,
        CLS_STORE   = 3'd3,
        CLS_BRANCH  = 3'd4,
        CLS_JAL     = 3'd5,
        CLS_JALR    = 3'd6,
        CLS_ILLEGAL = 3'd7
    } instr_class_t;

    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_STALL = 1'b1
    } stall_state_t;

    ////////////////////
    // Major opcodes
    ////////////////////
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam alu_op_t ALU_ADD = '0;

endpackage

//--- source/rv_decode_settings.svh
/*
 * Width settings for the RV32I decode stage.
 * The immediate formats assume XLEN is 32; other values are not supported.
 * Included by the package and the testbench.
 */
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Data and instruction word width
`define XLEN 32

// Register file index, x0..x31
`define REG_AW 5

`define OPCODE_W 7

// {bit30, funct3}
`define ALU_OP_W 4

// {store, funct3}
`define LSU_CTRL_W 4

`endif

//--- verif/decoder_tb_table.svh
/*
 * Decode table, one row per instruction, applied in order.
 * Columns: word, stall, class, alu_op, rs1, rs2, rd, rd_we, use_imm, imm, lsu_ctrl, illegal
 * Stall expectations rely on the row order, since each row sees the rd of the one before.
 */
task automatic fill_table();
    add_row(32'h003100B3, 0, CLS_ALU, 4'h0, 5'd2, 5'd3, 5'd1, 1, 0, 32'h00000000, 4'h0, 0);
    add_row(32'h40628233, 0, CLS_ALU, 4'h8, 5'd5, 5'd6, 5'd4, 1, 0, 32'h00000000, 4'h0, 0);
    // SRA reads x4 from SUB
    add_row(32'h401253B3, 1, CLS_ALU, 4'hD, 5'd4, 5'd1, 5'd7, 1, 0, 32'h00000000, 4'h0, 0);
    add_row(32'hFFB00413, 0, CLS_ALU, 4'h0, 5'd0, 5'd0, 5'd8, 1, 1, 32'hFFFFFFFB, 4'h0, 0);
    add_row(32'h40745493, 1, CLS_ALU, 4'hD, 5'd8, 5'd0, 5'd9, 1, 1, 32'h00000007, 4'h0, 0);
    // XORI with bit 30 set, which is immediate data here
    add_row(32'hFFF0C513, 0, CLS_ALU, 4'h4, 5'd1, 5'd0, 5'd10, 1, 1, 32'hFFFFFFFF, 4'h0, 0);
    add_row(32'h01F51593, 1, CLS_ALU, 4'h1, 5'd10, 5'd0, 5'd11, 1, 1, 32'h0000001F, 4'h0, 0);
    add_row(32'hABCDE637, 0, CLS_UPPER, 4'h0, 5'd0, 5'd0, 5'd12, 1, 1, 32'hABCDE000, 4'h0, 0);
    add_row(32'h80000697, 0, CLS_UPPER, 4'h0, 5'd0, 5'd0, 5'd13, 1, 1, 32'h80000000, 4'h0, 0);
    add_row(32'hFFC6A703, 1, CLS_LOAD, 4'h0, 5'd13, 5'd0, 5'd14, 0, 1, 32'hFFFFFFFC, 4'h2, 0);
    // SW reads x14 written by the load
    add_row(32'h00E12423, 1, CLS_STORE, 4'h0, 5'd2, 5'd14, 5'd0, 0, 1, 32'h00000008, 4'hA, 0);
    // SB reads x8, the store's rd bits, which are immediate
    add_row(32'hFE340FA3, 0, CLS_STORE, 4'h0, 5'd8, 5'd3, 5'd0, 0, 1, 32'hFFFFFFFF, 4'h8, 0);
    add_row(32'hFE208CE3, 0, CLS_BRANCH, 4'h0, 5'd1, 5'd2, 5'd0, 0, 1, 32'hFFFFFFF8, 4'h0, 0);
    // Reads x25, the branch's rd bits, which are immediate
    add_row(32'h019C87B3, 0, CLS_ALU, 4'h0, 5'd25, 5'd25, 5'd15, 1, 0, 32'h00000000, 4'h0, 0);
    add_row(32'h001000EF, 0, CLS_JAL, 4'h0, 5'd0, 5'd0, 5'd1, 1, 1, 32'h00000800, 4'h0, 0);
    add_row(32'hFF008067, 1, CLS_JALR, 4'h0, 5'd1, 5'd0, 5'd0, 1, 1, 32'hFFFFFFF0, 4'h0, 0);
    add_row(32'h00128013, 0, CLS_ALU, 4'h0, 5'd5, 5'd0, 5'd0, 1, 1, 32'h00000001, 4'h0, 0);
    // Reads x0 right after a write to x0
    add_row(32'h005009B3, 0, CLS_ALU, 4'h0, 5'd0, 5'd5, 5'd19, 1, 0, 32'h00000000, 4'h0, 0);
    // FENCE, ECALL, undefined opcode
    add_row(32'h0FF0000F, 0, CLS_ILLEGAL, 4'h0, 5'd0, 5'd0, 5'd0, 0, 0, 32'h0, 4'h0, 1);
    add_row(32'h00000073, 0, CLS_ILLEGAL, 4'h0, 5'd0, 5'd0, 5'd0, 0, 0, 32'h0, 4'h0, 1);
    add_row(32'h1234567F, 0, CLS_ILLEGAL, 4'h0, 5'd0, 5'd0, 5'd0, 0, 0, 32'h0, 4'h0, 1);
endtask

//--- verif/decoder_tb.sv
`timescale 1ns/1ns
/*
 * Table-driven testbench for the RV32I decode stage.
 * Rows are applied in order with random idle gaps of 0 to 3 cycles.
 * Stops at the first mismatch or expired wait.
 */
`include "rv_decode_settings.svh"

module decoder_tb;
    import rv_decode_pkg::*;

    localparam int MAX_ROWS   = 32;
    localparam int WAIT_LIMIT = 20;  // Cycles before any wait gives up

    logic         clk_i;
    logic         rstn_i;
    logic         instr_valid_i;
    word_t        instr_i;
    word_t        instr_addr_i;
    logic         ready_o;
    logic         dec_valid_o;
    logic         rd_we_o;
    logic         use_imm_o;
    logic         illegal_o;
    instr_class_t instr_class_o;
    alu_op_t      alu_op_o;
    reg_addr_t    rs1_addr_o;
    reg_addr_t    rs2_addr_o;
    reg_addr_t    rd_addr_o;
    word_t        imm_o;
    word_t        instr_addr_o;
    lsu_ctrl_t    lsu_ctrl_o;

    integer seed;

    ////////////////////
    // Expected values
    ////////////////////
    int           n_rows;
    word_t        tbl_word  [MAX_ROWS];
    logic         tbl_stall [MAX_ROWS];
    instr_class_t tbl_class [MAX_ROWS];
    alu_op_t      tbl_alu   [MAX_ROWS];
    reg_addr_t    tbl_rs1   [MAX_ROWS];
    reg_addr_t    tbl_rs2   [MAX_ROWS];
    reg_addr_t    tbl_rd    [MAX_ROWS];
    logic         tbl_we    [MAX_ROWS];
    logic         tbl_use   [MAX_ROWS];
    word_t        tbl_imm   [MAX_ROWS];
    lsu_ctrl_t    tbl_lsu   [MAX_ROWS];
    logic         tbl_ill   [MAX_ROWS];

    decoder_top UUT (
        .clk_i, .rstn_i, .instr_valid_i, .instr_i, .instr_addr_i,
        .ready_o, .dec_valid_o, .rd_we_o, .use_imm_o, .illegal_o, .instr_class_o,
        .alu_op_o, .rs1_addr_o, .rs2_addr_o, .rd_addr_o, .imm_o, .instr_addr_o,
        .lsu_ctrl_o
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic add_row(input word_t w, input logic stall, input instr_class_t cls,
                           input alu_op_t alu, input reg_addr_t rs1, input reg_addr_t rs2,
                           input reg_addr_t rd, input logic we, input logic use_imm,
                           input word_t imm, input lsu_ctrl_t lsu, input logic ill);
        tbl_word[n_rows]  = w;
        tbl_stall[n_rows] = stall;
        tbl_class[n_rows] = cls;
        tbl_alu[n_rows]   = alu;
        tbl_rs1[n_rows]   = rs1;
        tbl_rs2[n_rows]   = rs2;
        tbl_rd[n_rows]    = rd;
        tbl_we[n_rows]    = we;
        tbl_use[n_rows]   = use_imm;
        tbl_imm[n_rows]   = imm;
        tbl_lsu[n_rows]   = lsu;
        tbl_ill[n_rows]   = ill;
        n_rows++;
    endtask

    `include "decoder_tb_table.svh"

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is x%0d, expected x%0d",
                                        $time, what, got, exp));
    endtask

    task automatic check_alu_op(input string what, input alu_op_t got, input alu_op_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic check_lsu(input string what, input lsu_ctrl_t got, input lsu_ctrl_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic check_class(input string what, input instr_class_t got,
                               input instr_class_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is %s, expected %s",
                                        $time, what, got.name(), exp.name()));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
    endtask

    function automatic word_t row_addr(input int idx);
        return word_t'(32'h0000_1000 + idx * 4);
    endfunction

    function automatic int next_gap();
        return $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
    endfunction

    task automatic drive_row(input int idx);
        instr_valid_i <= 1'b1;
        instr_i       <= tbl_word[idx];
        instr_addr_i  <= row_addr(idx);
    endtask

    task automatic check_row(input int idx);
        check_class("instr_class_o", instr_class_o, tbl_class[idx]);
        check_alu_op("alu_op_o", alu_op_o, tbl_alu[idx]);
        check_reg("rs1_addr_o", rs1_addr_o, tbl_rs1[idx]);
        check_reg("rs2_addr_o", rs2_addr_o, tbl_rs2[idx]);
        check_reg("rd_addr_o", rd_addr_o, tbl_rd[idx]);
        check_bit("rd_we_o", rd_we_o, tbl_we[idx]);
        check_bit("use_imm_o", use_imm_o, tbl_use[idx]);
        check_word("imm_o", imm_o, tbl_imm[idx]);
        check_lsu("lsu_ctrl_o", lsu_ctrl_o, tbl_lsu[idx]);
        check_bit("illegal_o", illegal_o, tbl_ill[idx]);
        check_word("instr_addr_o", instr_addr_o, row_addr(idx));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int gap;
        int stalls;
        int waits;

        seed          = 32'h6ddb;
        n_rows        = 0;
        rstn_i        <= 1'b0;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        instr_addr_i  <= '0;
        fill_table();

        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check_bit("ready_o after reset", ready_o, 1'b1);
        check_bit("dec_valid_o after reset", dec_valid_o, 1'b0);
        check_bit("rd_we_o after reset", rd_we_o, 1'b0);
        check_bit("illegal_o after reset", illegal_o, 1'b0);

        gap = next_gap();
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        drive_row(0);
        @(negedge clk_i);

        for (int i = 0; i < n_rows; i++) begin
            stalls = 0;
            while (ready_o !== 1'b1) begin
                stalls++;
                if (stalls > WAIT_LIMIT)
                    stop_with_failure("Timeout: ready_o never went high for a pending row");
                @(negedge clk_i);
            end
            check_bit("stall before accept", stalls != 0, tbl_stall[i]);
            check_bit("stall no longer than one cycle", stalls <= 1, 1'b1);

            @(posedge clk_i);  // Accept edge
            gap = (i + 1 < n_rows) ? next_gap() : 1;
            if (gap == 0 && i + 1 < n_rows)
                drive_row(i + 1);  // Back to back
            else
                instr_valid_i <= 1'b0;

            @(negedge clk_i);
            waits = 0;
            while (dec_valid_o !== 1'b1) begin
                waits++;
                if (waits > WAIT_LIMIT)
                    stop_with_failure("Timeout: dec_valid_o never rose after an accept");
                @(negedge clk_i);
            end
            check_bit("dec_valid_o one cycle after accept", waits == 0, 1'b1);
            check_row(i);

            if (gap > 0 && i + 1 < n_rows) begin
                repeat (gap) @(posedge clk_i);
                drive_row(i + 1);
                @(negedge clk_i);
            end
        end

        @(negedge clk_i);
        check_bit("dec_valid_o pulse width", dec_valid_o, 1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule
